//--- Makefile
SRCS := $(shell cat drs_readout.f)

obj_dir/Vdrs_readout_tb: drs_readout.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module drs_readout_tb -f drs_readout.f

run: obj_dir/Vdrs_readout_tb
	./obj_dir/Vdrs_readout_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

check:
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run check clean

//--- common/drs_chip_pkg.sv
`default_nettype none

package drs_chip_pkg;

  // --------------------
  // adc
  // --------------------

  localparam int ADC_WIDTH = 14;
  typedef logic [ADC_WIDTH-1:0] adc_word_t;

  // --------------------
  // channels
  // --------------------

  // 8 signal channels plus the reference channel 8
  localparam int NUM_CHANNELS = 9;
  typedef logic [$clog2(NUM_CHANNELS)-1:0] chn_idx_t;
  typedef logic [NUM_CHANNELS-1:0]         chn_mask_t;

  // address pin opcodes, channel numbers 0..8 share the same pins
  typedef enum logic [3:0] {
    READ_SR  = 4'b1011,
    CONFIG   = 4'b1100,
    WRITE_SR = 4'b1101,
    STANDBY  = 4'b1111
  } drs_addr_e;

  // config reg: bit0 dmode, bit1 pllen, bit2 wsrloop
  typedef logic [7:0] sr_word_t;
  // bits 3..7 reserved, chip wants them written as 1
  localparam sr_word_t CONFIG_RESERVED = 8'hf8;

endpackage

`default_nettype wire

//--- common/drs_seq_pkg.sv
`default_nettype none

package drs_seq_pkg;

  // readout sequencer states
  typedef enum logic [3:0] {
    INIT,
    IDLE,
    CONF_SETUP,
    CONF_WRITE,
    WSR_SETUP,
    WSR_STROBE,
    START_RUNNING,
    RUNNING,
    TRIGGER,
    WAIT_VDD,
    INIT_READOUT,
    ADC_READOUT
  } seq_state_e;

  // controller settings
  typedef logic [5:0]  latency_t;
  typedef logic [9:0]  sample_count_t;
  typedef logic [15:0] vdd_count_t;

endpackage

`default_nettype wire

//--- drs_readout.f
common/drs_chip_pkg.sv
common/drs_seq_pkg.sv
rtl/drs_serial_loader.sv
rtl/drs_sample_capture.sv
sequencer/drs_channel_scan.sv
sequencer/drs_sequencer.sv
rtl/drs_readout_top.sv
test/drs_readout_tb.sv

//--- rtl/drs_readout_top.sv
`timescale 1ns/1ps
`default_nettype none

module drs_readout_top
  import drs_chip_pkg::*;
  import drs_seq_pkg::*;
#(
  // domino cycles before the trigger is armed
  parameter int WARMUP_CYCLES = 105
) (
  input  wire                clock,
  input  wire                reset,
  input  wire                trigger_i,
  input  wire adc_word_t     adc_data_i,
  // control settings
  input  wire                drs_ctl_dmode_i,
  input  wire latency_t      drs_ctl_adc_latency_i,
  input  wire vdd_count_t    drs_ctl_wait_vdd_clocks_i,
  input  wire sample_count_t drs_ctl_sample_count_max_i,
  input  wire sr_word_t      drs_ctl_config_i,
  input  wire sr_word_t      drs_ctl_chn_config_i,
  input  wire                drs_ctl_start_i,
  input  wire                drs_ctl_reinit_i,
  input  wire                drs_ctl_configure_i,
  input  wire logic [7:0]    drs_ctl_readout_mask_i,
  // chip pins
  input  wire                drs_srout_i,
  output logic [3:0]         drs_addr_o,
  output logic               drs_nreset_o,
  output logic               drs_denable_o,
  output logic               drs_dwrite_o,
  output logic               drs_srclk_en_o,
  output logic               drs_srin_o,
  // fifo and status
  output adc_word_t          fifo_wdata_o,
  output logic               fifo_wen_o,
  output logic               readout_complete_o,
  output logic               busy_o
);

  // sequencer <-> loader
  logic     load;
  sr_word_t load_word;
  logic     shift_clk_en;
  logic     shift_bit;
  logic     shift_done;

  // sequencer <-> capture
  logic readout_active;
  logic channel_done;
  logic read_clk_en;

  drs_sequencer #(
    .WARMUP_CYCLES (WARMUP_CYCLES)
  ) u_sequencer (
    .clock                     (clock),
    .reset                     (reset),
    .trigger_i                 (trigger_i),
    .drs_ctl_dmode_i           (drs_ctl_dmode_i),
    .drs_ctl_wait_vdd_clocks_i (drs_ctl_wait_vdd_clocks_i),
    .drs_ctl_config_i          (drs_ctl_config_i),
    .drs_ctl_chn_config_i      (drs_ctl_chn_config_i),
    .drs_ctl_start_i           (drs_ctl_start_i),
    .drs_ctl_reinit_i          (drs_ctl_reinit_i),
    .drs_ctl_configure_i       (drs_ctl_configure_i),
    .drs_ctl_readout_mask_i    (drs_ctl_readout_mask_i),
    .channel_done_i            (channel_done),
    .read_clk_en_i             (read_clk_en),
    .shift_done_i              (shift_done),
    .shift_clk_en_i            (shift_clk_en),
    .shift_bit_i               (shift_bit),
    .drs_addr_o                (drs_addr_o),
    .drs_nreset_o              (drs_nreset_o),
    .drs_denable_o             (drs_denable_o),
    .drs_dwrite_o              (drs_dwrite_o),
    .drs_srclk_en_o            (drs_srclk_en_o),
    .drs_srin_o                (drs_srin_o),
    .readout_active_o          (readout_active),
    .load_o                    (load),
    .load_word_o               (load_word),
    .readout_complete_o        (readout_complete_o),
    .busy_o                    (busy_o)
  );

  drs_sample_capture u_sample_capture (
    .clock              (clock),
    .reset              (reset),
    .adc_data_i         (adc_data_i),
    .readout_active_i   (readout_active),
    .adc_latency_i      (drs_ctl_adc_latency_i),
    .sample_count_max_i (drs_ctl_sample_count_max_i),
    .fifo_wdata_o       (fifo_wdata_o),
    .fifo_wen_o         (fifo_wen_o),
    .channel_done_o     (channel_done),
    .read_clk_en_o      (read_clk_en)
  );

  drs_serial_loader u_serial_loader (
    .clock          (clock),
    .reset          (reset),
    .load_i         (load),
    .load_word_i    (load_word),
    .shift_clk_en_o (shift_clk_en),
    .shift_bit_o    (shift_bit),
    .shift_done_o   (shift_done)
  );

endmodule

`default_nettype wire

//--- rtl/drs_sample_capture.sv
`timescale 1ns/1ps
`default_nettype none

module drs_sample_capture
  import drs_chip_pkg::*;
  import drs_seq_pkg::*;
(
  input  wire                clock,
  input  wire                reset,
  input  wire adc_word_t     adc_data_i,
  input  wire                readout_active_i,
  input  wire latency_t      adc_latency_i,
  input  wire sample_count_t sample_count_max_i,
  output adc_word_t          fifo_wdata_o,
  output logic               fifo_wen_o,
  output logic               channel_done_o,
  output logic               read_clk_en_o
);

  // room for latency plus a full channel of samples
  localparam int CYC_W = $bits(sample_count_t) + 1;

  adc_word_t        adc_neg;
  adc_word_t        adc_q;
  logic [CYC_W-1:0] cyc_cnt;
  sample_count_t    smp_cnt;
  logic             take;

  // --------------------
  // input flops
  // --------------------

  // adc runs off the same clock, capture mid-cycle
  always_ff @(negedge clock) begin
    adc_neg <= adc_data_i;
  end

  always_ff @(posedge clock) begin
    adc_q <= adc_neg;
  end

  // --------------------
  // sample counting
  // --------------------

  // skip the adc pipeline delay
  assign take           = readout_active_i && (cyc_cnt > CYC_W'(adc_latency_i));
  assign channel_done_o = take && (smp_cnt + 1'b1 == sample_count_max_i);

  always_ff @(posedge clock) begin
    if (reset || !readout_active_i) begin
      cyc_cnt       <= '0;
      smp_cnt       <= '0;
      fifo_wen_o    <= 1'b0;
      read_clk_en_o <= 1'b0;
    end else begin
      fifo_wen_o    <= take;
      read_clk_en_o <= (cyc_cnt + 1'b1 < CYC_W'(sample_count_max_i));
      // restart for the next channel
      if (channel_done_o) begin
        cyc_cnt <= '0;
        smp_cnt <= '0;
      end else begin
        cyc_cnt <= cyc_cnt + 1'b1;
        if (take) begin
          smp_cnt <= smp_cnt + 1'b1;
        end
      end
    end
  end

  // fifo data, no back-pressure
  always_ff @(posedge clock) begin
    if (take) begin
      fifo_wdata_o <= adc_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/drs_serial_loader.sv
`timescale 1ns/1ps
`default_nettype none

module drs_serial_loader
  import drs_chip_pkg::*;
(
  input  wire           clock,
  input  wire           reset,
  input  wire           load_i,
  input  wire sr_word_t load_word_i,
  output logic          shift_clk_en_o,
  output logic          shift_bit_o,
  output logic          shift_done_o
);

  localparam int SR_W  = $bits(sr_word_t);
  localparam int CNT_W = $clog2(SR_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SR_W - 1);

  sr_word_t         shift_reg;
  logic [CNT_W-1:0] bit_cnt;
  logic             active;

  // msb first onto srin
  assign shift_clk_en_o = active;
  assign shift_bit_o    = active & shift_reg[SR_W-1];
  assign shift_done_o   = active && (bit_cnt == LAST_BIT);

  // bit counter
  always_ff @(posedge clock) begin
    if (reset) begin
      active  <= 1'b0;
      bit_cnt <= '0;
    end else if (load_i) begin
      active  <= 1'b1;
      bit_cnt <= '0;
    end else if (active) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == LAST_BIT) begin
        active <= 1'b0;
      end
    end
  end

  // data shifter
  always_ff @(posedge clock) begin
    if (load_i) begin
      shift_reg <= load_word_i;
    end else if (active) begin
      shift_reg <= {shift_reg[SR_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- sequencer/drs_channel_scan.sv
`timescale 1ns/1ps
`default_nettype none

module drs_channel_scan
  import drs_chip_pkg::*;
(
  input  wire             clock,
  input  wire             reset,
  input  wire             scan_start_i,
  input  wire             channel_done_i,
  input  wire logic [7:0] readout_mask_i,
  output chn_idx_t        current_chn_o,
  output logic            last_chn_o,
  output logic            mask_any_o
);

  chn_mask_t mask_ext;
  chn_mask_t remaining;
  chn_mask_t remaining_next;

  // lowest set bit, 0 when the mask is empty
  function automatic chn_idx_t lowest_chn(input chn_mask_t mask);
    chn_idx_t idx;
    idx = '0;
    for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = chn_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // channel 8 rides along with any enabled channel
  assign mask_any_o = |readout_mask_i;
  assign mask_ext   = {mask_any_o, readout_mask_i};

  // what is left once the current channel is read
  assign remaining_next = remaining & ~(chn_mask_t'(1) << current_chn_o);
  assign last_chn_o     = (remaining_next == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining     <= '0;
      current_chn_o <= '0;
    end else if (scan_start_i) begin
      remaining     <= mask_ext;
      current_chn_o <= lowest_chn(mask_ext);
    end else if (channel_done_i) begin
      // drop current, look ahead to the next enabled one
      remaining     <= remaining_next;
      current_chn_o <= lowest_chn(remaining_next);
    end
  end

endmodule

`default_nettype wire

//--- sequencer/drs_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module drs_sequencer
  import drs_chip_pkg::*;
  import drs_seq_pkg::*;
#(
  parameter int WARMUP_CYCLES = 105
) (
  input  wire             clock,
  input  wire             reset,
  input  wire             trigger_i,
  input  wire             drs_ctl_dmode_i,
  input  wire vdd_count_t drs_ctl_wait_vdd_clocks_i,
  input  wire sr_word_t   drs_ctl_config_i,
  input  wire sr_word_t   drs_ctl_chn_config_i,
  input  wire             drs_ctl_start_i,
  input  wire             drs_ctl_reinit_i,
  input  wire             drs_ctl_configure_i,
  input  wire logic [7:0] drs_ctl_readout_mask_i,
  input  wire             channel_done_i,
  input  wire             read_clk_en_i,
  input  wire             shift_done_i,
  input  wire             shift_clk_en_i,
  input  wire             shift_bit_i,
  output logic [3:0]      drs_addr_o,
  output logic            drs_nreset_o,
  output logic            drs_denable_o,
  output logic            drs_dwrite_o,
  output logic            drs_srclk_en_o,
  output logic            drs_srin_o,
  output logic            readout_active_o,
  output logic            load_o,
  output sr_word_t        load_word_o,
  output logic            readout_complete_o,
  output logic            busy_o
);

  localparam int WARM_W = $clog2(WARMUP_CYCLES + 1);
  localparam logic [WARM_W-1:0] WARM_LAST = WARM_W'(WARMUP_CYCLES - 1);

  seq_state_e        state;
  drs_addr_e         addr_q;
  logic              reinit_req;
  logic              init_cnt;
  logic              armed;
  logic              trig_q;
  logic              dwrite_set;
  logic [WARM_W-1:0] warm_cnt;
  vdd_count_t        wait_cnt;

  logic     scan_start;
  chn_idx_t current_chn;
  logic     last_chn;
  logic     mask_any;
  logic     conf_state;
  logic     shift_state;
  logic     chan_state;
  logic     reinit_go;

  // --------------------
  // state decode
  // --------------------

  assign conf_state  = (state == CONF_SETUP) || (state == CONF_WRITE) ||
                       (state == WSR_SETUP)  || (state == WSR_STROBE);
  assign shift_state = (state == CONF_WRITE) || (state == WSR_STROBE);
  assign chan_state  = (state == INIT_READOUT) || (state == ADC_READOUT);
  // configuration always runs to completion
  assign reinit_go   = reinit_req && !conf_state && (state != INIT);

  assign scan_start       = (state == TRIGGER);
  assign readout_active_o = (state == ADC_READOUT);

  // serial words for the loader
  assign load_o      = (state == CONF_SETUP) || (state == WSR_SETUP);
  assign load_word_o = (state == CONF_SETUP) ? (drs_ctl_config_i | CONFIG_RESERVED)
                                             : drs_ctl_chn_config_i;

  // channel number on the address pins while reading out
  assign drs_addr_o = chan_state ? current_chn : addr_q;

  // srclk shared by config shift-out and readout
  always_comb begin
    drs_srclk_en_o = 1'b0;
    drs_srin_o     = 1'b0;
    if (shift_state) begin
      drs_srclk_en_o = shift_clk_en_i;
      drs_srin_o     = shift_bit_i;
    end else if (readout_active_o) begin
      drs_srclk_en_o = read_clk_en_i;
    end
  end

  // --------------------
  // trigger and dwrite
  // --------------------

  // only armed after warm-up, and only with something to read
  always_ff @(posedge clock) begin
    if (reset) begin
      trig_q       <= 1'b0;
      drs_dwrite_o <= 1'b0;
    end else begin
      trig_q       <= trigger_i && armed && mask_any;
      drs_dwrite_o <= dwrite_set;
    end
  end

  drs_channel_scan u_channel_scan (
    .clock          (clock),
    .reset          (reset),
    .scan_start_i   (scan_start),
    .channel_done_i (channel_done_i),
    .readout_mask_i (drs_ctl_readout_mask_i),
    .current_chn_o  (current_chn),
    .last_chn_o     (last_chn),
    .mask_any_o     (mask_any)
  );

  // --------------------
  // main fsm
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state              <= INIT;
      addr_q             <= STANDBY;
      drs_nreset_o       <= 1'b0;
      drs_denable_o      <= 1'b0;
      dwrite_set         <= 1'b0;
      busy_o             <= 1'b0;
      readout_complete_o <= 1'b0;
      reinit_req         <= 1'b0;
      init_cnt           <= 1'b0;
      armed              <= 1'b0;
      warm_cnt           <= '0;
      wait_cnt           <= '0;
    end else begin
      readout_complete_o <= 1'b0;
      init_cnt           <= 1'b0;

      // reinit is a one-cycle pulse, hold it until INIT
      if (drs_ctl_reinit_i) begin
        reinit_req <= 1'b1;
      end

      if (reinit_go) begin
        state        <= INIT;
        drs_nreset_o <= 1'b0;
        armed        <= 1'b0;
      end else begin
        case (state)
          // chip reset, nreset low for 2 cycles
          INIT: begin
            drs_nreset_o  <= 1'b0;
            drs_denable_o <= 1'b0;
            dwrite_set    <= 1'b0;
            busy_o        <= 1'b0;
            armed         <= 1'b0;
            reinit_req    <= 1'b0;
            init_cnt      <= 1'b1;
            if (init_cnt) begin
              state        <= IDLE;
              drs_nreset_o <= 1'b1;
              addr_q       <= READ_SR;
            end
          end

          IDLE: begin
            drs_nreset_o <= 1'b1;
            addr_q       <= READ_SR;
            busy_o       <= 1'b0;
            armed        <= 1'b0;
            warm_cnt     <= '0;
            wait_cnt     <= '0;
            if (drs_ctl_configure_i) begin
              state <= CONF_SETUP;
            end else if (drs_ctl_start_i) begin
              state         <= START_RUNNING;
              busy_o        <= 1'b1;
              // start domino wave, dwrite follows a cycle later
              drs_denable_o <= 1'b1;
              dwrite_set    <= 1'b1;
            end
          end

          // config register, first bit goes out with the address
          CONF_SETUP: begin
            addr_q <= CONFIG;
            state  <= CONF_WRITE;
          end

          CONF_WRITE: begin
            if (shift_done_i) begin
              state <= WSR_SETUP;
            end
          end

          // write shift register, channel enables
          WSR_SETUP: begin
            addr_q <= WRITE_SR;
            state  <= WSR_STROBE;
          end

          WSR_STROBE: begin
            if (shift_done_i) begin
              state  <= IDLE;
              addr_q <= READ_SR;
            end
          end

          // let the domino wave go round before arming
          START_RUNNING: begin
            if (warm_cnt == WARM_LAST) begin
              state <= RUNNING;
              armed <= 1'b1;
            end else begin
              warm_cnt <= warm_cnt + 1'b1;
            end
          end

          // single shot falls straight through
          RUNNING: begin
            if (trig_q || !drs_ctl_dmode_i) begin
              state      <= TRIGGER;
              dwrite_set <= 1'b0;
              armed      <= 1'b0;
            end
          end

          TRIGGER: begin
            addr_q   <= READ_SR;
            wait_cnt <= '0;
            state    <= WAIT_VDD;
          end

          // supply settling, wait_vdd + 1 cycles
          WAIT_VDD: begin
            if (wait_cnt == drs_ctl_wait_vdd_clocks_i) begin
              state <= INIT_READOUT;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end

          INIT_READOUT: begin
            state <= ADC_READOUT;
          end

          // capture counts samples, scan steps channels
          ADC_READOUT: begin
            if (channel_done_i && last_chn) begin
              state              <= IDLE;
              readout_complete_o <= 1'b1;
              busy_o             <= 1'b0;
            end
          end

          default: begin
            state <= INIT;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- test/drs_readout_tb.sv
`timescale 1ns/1ps
`default_nettype none

module drs_readout_tb
  import drs_chip_pkg::*;
  import drs_seq_pkg::*;
();

  localparam int WARMUP     = 10;
  localparam int WAIT_LIMIT = 3000;

  // pins that the wait loops can watch
  typedef enum int {
    SIG_NRESET,
    SIG_DENABLE,
    SIG_DWRITE,
    SIG_SRCLK_EN,
    SIG_BUSY,
    SIG_COMPLETE
  } probe_e;

  // dut inputs
  logic          clock;
  logic          reset;
  logic          trigger;
  adc_word_t     adc_data;
  logic          ctl_dmode;
  latency_t      ctl_latency;
  vdd_count_t    ctl_wait_vdd;
  sample_count_t ctl_smax;
  sr_word_t      ctl_config;
  sr_word_t      ctl_chn_config;
  logic          ctl_start;
  logic          ctl_reinit;
  logic          ctl_configure;
  logic [7:0]    ctl_mask;
  logic          srout;

  // dut outputs
  logic [3:0] drs_addr;
  logic       drs_nreset;
  logic       drs_denable;
  logic       drs_dwrite;
  logic       drs_srclk_en;
  logic       drs_srin;
  adc_word_t  fifo_wdata;
  logic       fifo_wen;
  logic       readout_complete;
  logic       busy;

  int seed;
  int check_errors;
  int monitor_errors = 0;

  // expected readout from the reference function
  logic [35:0] exp_list;
  int          exp_n;
  int          exp_words;

  // monitor control and results
  logic       mon_clear;
  logic       expect_busy;
  int         wr_count       = 0;
  int         chn_pos        = 0;
  int         complete_count = 0;
  logic [3:0] last_addr      = 4'hf;
  adc_word_t  prev_word      = '0;

  // raised by a wait that gave up
  event timeout_ev;

  drs_readout_top #(
    .WARMUP_CYCLES (WARMUP)
  ) uut (
    .clock                      (clock),
    .reset                      (reset),
    .trigger_i                  (trigger),
    .adc_data_i                 (adc_data),
    .drs_ctl_dmode_i            (ctl_dmode),
    .drs_ctl_adc_latency_i      (ctl_latency),
    .drs_ctl_wait_vdd_clocks_i  (ctl_wait_vdd),
    .drs_ctl_sample_count_max_i (ctl_smax),
    .drs_ctl_config_i           (ctl_config),
    .drs_ctl_chn_config_i       (ctl_chn_config),
    .drs_ctl_start_i            (ctl_start),
    .drs_ctl_reinit_i           (ctl_reinit),
    .drs_ctl_configure_i        (ctl_configure),
    .drs_ctl_readout_mask_i     (ctl_mask),
    .drs_srout_i                (srout),
    .drs_addr_o                 (drs_addr),
    .drs_nreset_o               (drs_nreset),
    .drs_denable_o              (drs_denable),
    .drs_dwrite_o               (drs_dwrite),
    .drs_srclk_en_o             (drs_srclk_en),
    .drs_srin_o                 (drs_srin),
    .fifo_wdata_o               (fifo_wdata),
    .fifo_wen_o                 (fifo_wen),
    .readout_complete_o         (readout_complete),
    .busy_o                     (busy)
  );

  // --------------------
  // clock and adc model
  // --------------------

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // adc ramp with one step per clock
  initial begin
    adc_data <= '0;
    forever begin
      @(posedge clock);
      adc_data <= adc_data + 1'b1;
    end
  end

  // --------------------
  // reference model
  // --------------------

  // channels in readout order with channel 8 last plus the word total
  function automatic void reference_readout(
    input  logic [7:0]    mask,
    input  sample_count_t smax,
    output logic [35:0]   chn_list,
    output int            n_chn,
    output int            n_words
  );
    chn_list = '0;
    n_chn    = 0;
    for (int i = 0; i < 8; i++) begin
      if (mask[i]) begin
        chn_list[n_chn*4 +: 4] = 4'(i);
        n_chn++;
      end
    end
    if (mask != 8'h00) begin
      chn_list[n_chn*4 +: 4] = 4'd8;
      n_chn++;
    end
    n_words = n_chn * int'(smax);
  endfunction

  // --------------------
  // readout monitor
  // --------------------

  always @(negedge clock) begin : readout_monitor
    logic [3:0] exp_chn;
    adc_word_t  next_word;
    if (mon_clear) begin
      wr_count       = 0;
      chn_pos        = 0;
      complete_count = 0;
      last_addr      = 4'hf;
    end else if (!reset) begin
      // every new channel number on the address pins
      if (drs_addr < 4'd9 && drs_addr != last_addr) begin
        assert (chn_pos < exp_n) else begin
          $display("Error: channel %0d was read after the expected list ended", drs_addr);
          monitor_errors++;
        end
        exp_chn = (chn_pos < exp_n) ? exp_list[chn_pos*4 +: 4] : drs_addr;
        assert (drs_addr == exp_chn) else begin
          $display("** Error at %0t: drs_addr_o expected %0d, got %0d",
                   $time, exp_chn, drs_addr);
          monitor_errors++;
        end
        chn_pos++;
      end
      last_addr = drs_addr;
      // words inside one channel follow the ramp
      if (fifo_wen) begin
        if (ctl_smax != '0 && (wr_count % int'(ctl_smax)) != 0) begin
          next_word = prev_word + 1'b1;
          assert (fifo_wdata == next_word) else begin
            $display("** Error at %0t: fifo_wdata_o expected %0h, got %0h",
                     $time, next_word, fifo_wdata);
            monitor_errors++;
          end
        end
        prev_word = fifo_wdata;
        wr_count++;
      end
      if (readout_complete) begin
        complete_count++;
      end
      // busy drops on the same edge as the complete pulse
      if (expect_busy) begin
        assert (busy === !readout_complete) else begin
          $display("** Error at %0t: busy_o expected %0b, got %0b",
                   $time, !readout_complete, busy);
          monitor_errors++;
        end
      end
    end
  end

  // a wait that gave up ends the run
  initial begin : timeout_stop
    @(timeout_ev);
    $display("errors: %0d in checks, %0d in the monitor", check_errors, monitor_errors);
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------
  // helpers
  // --------------------

  function automatic logic probe(input probe_e sel);
    case (sel)
      SIG_NRESET:   return drs_nreset;
      SIG_DENABLE:  return drs_denable;
      SIG_DWRITE:   return drs_dwrite;
      SIG_SRCLK_EN: return drs_srclk_en;
      SIG_BUSY:     return busy;
      SIG_COMPLETE: return readout_complete;
      default:      return 1'bx;
    endcase
  endfunction

  // polls at falling edges and returns the cycles it took
  task automatic wait_level(input probe_e sel, input logic level, input int limit,
                            input string what, output int cycles);
    cycles = 0;
    @(negedge clock);
    while (probe(sel) !== level) begin
      if (cycles >= limit) begin
        $display("Timeout: %s never reached %0b", what, level);
        -> timeout_ev;
      end
      @(negedge clock);
      cycles++;
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic check_reset_state();
    check_value("drs_addr_o", int'(STANDBY), int'(drs_addr));
    check_value("drs_nreset_o", 0, int'(drs_nreset));
    check_value("drs_denable_o", 0, int'(drs_denable));
    check_value("drs_dwrite_o", 0, int'(drs_dwrite));
    check_value("drs_srclk_en_o", 0, int'(drs_srclk_en));
    check_value("drs_srin_o", 0, int'(drs_srin));
    check_value("fifo_wen_o", 0, int'(fifo_wen));
    check_value("busy_o", 0, int'(busy));
    check_value("readout_complete_o", 0, int'(readout_complete));
  endtask

  // one 8-bit word msb first with srclk_en high on every bit
  task automatic check_serial_word(input drs_addr_e addr, input sr_word_t expected,
                                   input string name);
    sr_word_t word;
    int       cycles;
    word = '0;
    wait_level(SIG_SRCLK_EN, 1'b1, 20, "drs_srclk_en_o", cycles);
    for (int i = 0; i < 8; i++) begin
      if (i > 0) begin
        @(negedge clock);
      end
      check_value("drs_srclk_en_o", 1, int'(drs_srclk_en));
      check_value("drs_addr_o", int'(addr), int'(drs_addr));
      word = {word[6:0], drs_srin};
    end
    check_value({"drs_srin_o ", name}, int'(expected), int'(word));
  endtask

  task automatic run_configure(input sr_word_t cfg, input sr_word_t chn_cfg);
    @(posedge clock);
    ctl_config     <= cfg;
    ctl_chn_config <= chn_cfg;
    ctl_configure  <= 1'b1;
    @(posedge clock);
    ctl_configure <= 1'b0;
    check_serial_word(CONFIG, cfg | CONFIG_RESERVED, "config word");
    check_serial_word(WRITE_SR, chn_cfg, "write shift register word");
    // back in idle after the last bit
    @(negedge clock);
    check_value("drs_srclk_en_o", 0, int'(drs_srclk_en));
    check_value("drs_addr_o", int'(READ_SR), int'(drs_addr));
  endtask

  // start pulse up to a running domino wave
  task automatic start_domino(input logic [7:0] mask, input sample_count_t smax,
                              input latency_t latency, input logic single_shot);
    int cycles;
    reference_readout(mask, smax, exp_list, exp_n, exp_words);
    @(posedge clock);
    ctl_mask    <= mask;
    ctl_smax    <= smax;
    ctl_latency <= latency;
    ctl_dmode   <= !single_shot;
    mon_clear = 1'b1;
    @(posedge clock);
    mon_clear = 1'b0;
    ctl_start <= 1'b1;
    @(posedge clock);
    ctl_start <= 1'b0;
    wait_level(SIG_DENABLE, 1'b1, 5, "drs_denable_o", cycles);
    check_value("busy_o", 1, int'(busy));
    // dwrite is due at the very next falling edge
    wait_level(SIG_DWRITE, 1'b1, 5, "drs_dwrite_o", cycles);
    check_value("drs_dwrite_o delay", 0, cycles);
    @(posedge clock);
    expect_busy = 1'b1;
  endtask

  task automatic pulse_trigger();
    @(posedge clock);
    trigger <= 1'b1;
    @(posedge clock);
    trigger <= 1'b0;
  endtask

  task automatic run_readout(input logic [7:0] mask, input sample_count_t smax,
                             input latency_t latency, input logic single_shot);
    int cycles;
    start_domino(mask, smax, latency, single_shot);
    if (single_shot) begin
      wait_level(SIG_DWRITE, 1'b0, WARMUP + 20, "drs_dwrite_o", cycles);
    end else begin
      // trigger only after the warm-up
      repeat (WARMUP + 5) @(negedge clock);
      check_value("drs_dwrite_o", 1, int'(drs_dwrite));
      @(posedge clock);
      check_value("fifo_wen_o writes before trigger", 0, wr_count);
      pulse_trigger();
      wait_level(SIG_DWRITE, 1'b0, 6, "drs_dwrite_o", cycles);
    end
    wait_level(SIG_COMPLETE, 1'b1, WAIT_LIMIT, "readout_complete_o", cycles);
    @(posedge clock);
    expect_busy = 1'b0;
    @(negedge clock);
    check_value("busy_o", 0, int'(busy));
    @(posedge clock);
    check_value("drs_addr_o channels read", exp_n, chn_pos);
    check_value("fifo_wen_o write count", exp_words, wr_count);
    check_value("readout_complete_o pulses", 1, complete_count);
  endtask

  // reinit from a running state goes back to idle through INIT
  task automatic run_reinit();
    int cycles;
    @(posedge clock);
    expect_busy = 1'b0;
    mon_clear   = 1'b1;
    ctl_reinit <= 1'b1;
    @(posedge clock);
    mon_clear = 1'b0;
    ctl_reinit <= 1'b0;
    wait_level(SIG_NRESET, 1'b0, 5, "drs_nreset_o", cycles);
    wait_level(SIG_BUSY, 1'b0, 5, "busy_o", cycles);
    wait_level(SIG_NRESET, 1'b1, 5, "drs_nreset_o", cycles);
    check_value("drs_denable_o", 0, int'(drs_denable));
    check_value("drs_dwrite_o", 0, int'(drs_dwrite));
    check_value("drs_addr_o", int'(READ_SR), int'(drs_addr));
    @(posedge clock);
    check_value("readout_complete_o pulses", 0, complete_count);
    check_value("fifo_wen_o write count", 0, wr_count);
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin : main_sequence
    int         cycles;
    int         rnd;
    logic [7:0] mask;
    seed         = 36;
    check_errors = 0;
    mon_clear    = 1'b0;
    expect_busy  = 1'b0;
    reset          <= 1'b1;
    trigger        <= 1'b0;
    ctl_dmode      <= 1'b1;
    ctl_latency    <= latency_t'(3);
    ctl_wait_vdd   <= vdd_count_t'(4);
    ctl_smax       <= sample_count_t'(8);
    ctl_config     <= '0;
    ctl_chn_config <= '0;
    ctl_start      <= 1'b0;
    ctl_reinit     <= 1'b0;
    ctl_configure  <= 1'b0;
    ctl_mask       <= 8'h00;
    srout          <= 1'b0;

    // reset then nreset low for two cycles
    repeat (4) @(posedge clock);
    @(negedge clock);
    check_reset_state();
    @(posedge clock);
    reset <= 1'b0;
    wait_level(SIG_NRESET, 1'b1, 10, "drs_nreset_o", cycles);
    check_value("drs_nreset_o low cycles", 2, cycles);
    check_value("drs_addr_o", int'(READ_SR), int'(drs_addr));

    rnd = $random(seed);
    run_configure(rnd[7:0], rnd[15:8]);

    // continuous mode with random masks
    for (int run = 0; run < 4; run++) begin
      rnd  = $random(seed);
      mask = (rnd[7:0] == 8'h00) ? 8'h01 : rnd[7:0];
      run_readout(mask, sample_count_t'(2 + int'(rnd[11:8])), latency_t'(rnd[14:12]), 1'b0);
    end

    // single shot without any trigger
    rnd  = $random(seed);
    mask = (rnd[7:0] == 8'h00) ? 8'h80 : rnd[7:0];
    run_readout(mask, sample_count_t'(5), latency_t'(2), 1'b1);

    // trigger has no effect with an empty mask
    start_domino(8'h00, sample_count_t'(4), latency_t'(3), 1'b0);
    repeat (WARMUP + 5) @(negedge clock);
    pulse_trigger();
    repeat (200) @(negedge clock);
    check_value("drs_dwrite_o", 1, int'(drs_dwrite));
    @(posedge clock);
    check_value("fifo_wen_o writes with empty mask", 0, wr_count);
    run_reinit();

    // reinit while waiting for a trigger
    rnd  = $random(seed);
    mask = (rnd[7:0] == 8'h00) ? 8'h10 : rnd[7:0];
    start_domino(mask, sample_count_t'(4), latency_t'(3), 1'b0);
    repeat (WARMUP + 5) @(negedge clock);
    run_reinit();

    $display("errors: %0d in checks, %0d in the monitor", check_errors, monitor_errors);
    if (check_errors + monitor_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
